// File: Makefile
VERILATOR ?= verilator
TOP       ?= ddr3_ctrl_tb
FILELIST  ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST)) verilog/ddr3_defs.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sources.f
+incdir+verilog
verilog/ddr3_pkg.sv
verilog/ddr3_req_arbiter.sv
verilog/ddr3_req_fifo.sv
verilog/ddr3_cmd_scheduler.sv
verilog/ddr3_ctrl_top.sv
test/ddr3_ctrl_checker.sv
test/ddr3_ctrl_tb.sv

// File: test/ddr3_ctrl_checker.sv
module ddr3_ctrl_checker (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      ddl_req_i,
  input  logic                      ddl_rdy_i,
  input  ddr3_pkg::ddr_cmd_t        ddl_cmd_i,
  input  logic [2:0]                ddl_ba_i,
  input  logic [12:0]               ddl_adr_i,
  input  logic [3:0]                ddl_tid_i,
  input  logic [7:0]                bank_open_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import ddr3_pkg::*;

  // a command waiting for ready keeps every field
  hold_cmd: assert property (@(posedge clock) disable iff (reset)
    ddl_req_i && !ddl_rdy_i |=> ddl_req_i && $stable({ddl_cmd_i, ddl_ba_i, ddl_adr_i, ddl_tid_i}))
    else $error("command fields changed while waiting for ready");

  // activate only opens a closed bank
  actv_closed: assert property (@(posedge clock) disable iff (reset)
    ddl_req_i && ddl_cmd_i == ACTV |-> !bank_open_i[ddl_ba_i])
    else $error("activate to an open bank");

  // nothing goes to the data layer under reset
  quiet_reset: assert property (@(posedge clock) reset |=> !ddl_req_i)
    else $error("data layer request during reset");

endmodule

// File: test/ddr3_ctrl_tb.sv
`include "ddr3_defs.svh"

module ddr3_ctrl_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ddr3_pkg::*;

  localparam int TOTAL = 2000;
  localparam int LIMIT = 8 + TOTAL * 12;

  logic clock, reset, cfg_run_i;
  logic mem_wrreq_i, mem_wrlst_i, mem_rdreq_i, mem_rdlst_i, byp_rdreq_i, byp_rdlst_i;
  logic [`DDR_TID_BITS-1:0]  mem_wrtid_i, mem_rdtid_i, byp_rdtid_i;
  logic [`DDR_ADDR_BITS-1:0] mem_wradr_i, mem_rdadr_i, byp_rdadr_i;
  logic mem_wrack_o, mem_rdack_o, byp_rdack_o;
  logic ddl_req_o, ddl_rdy_i, ddl_ref_i;
  ddr_cmd_t ddl_cmd_o;
  logic [`DDR_TID_BITS-1:0]  ddl_tid_o;
  logic [`DDR_BANK_BITS-1:0] ddl_ba_o;
  logic [`DDR_ROW_BITS-1:0]  ddl_adr_o;

  // reference model state
  ddr_req_t exp_q[$];
  logic [7:0]  m_open;
  logic [12:0] m_row [8];
  logic        in_req;
  // 0 none, 1 expect refresh, 2 wait for the level to fall
  int          ref_phase;
  logic        ref_at_dec;
  logic [2:0]  prev_reqs;
  int seed, cycle, errors, starts, accesses, stall_cnt, ref_cnt, drop_cnt;

  ddr3_ctrl_top ddr3_ctrl_top_inst (.*);

  bind ddr3_cmd_scheduler ddr3_ctrl_checker ddr3_ctrl_checker_inst (
    .clock(clock), .reset(reset), .ddl_req_i(ddl_req_o), .ddl_rdy_i(ddl_rdy_i),
    .ddl_cmd_i(ddl_cmd_o), .ddl_ba_i(ddl_ba_o), .ddl_adr_i(ddl_adr_o),
    .ddl_tid_i(ddl_tid_o), .bank_open_i(bank_open)
  );

  always #20 clock = ~clock;

  function automatic int urand(int n);
    int r;
    r = $random(seed);
    r = r & 32'h7fff_ffff;
    return r % n;
  endfunction

  // row pool of four so that hits and conflicts are common
  function automatic ddr_req_t rand_req(logic wr);
    ddr_req_t q;
    q.wr   = wr;
    q.last = urand(4) == 0;
    q.tid  = 4'(urand(16));
    q.adr  = {13'h100 + 13'(urand(4)), 3'(urand(8)), 7'(urand(128))};
    return q;
  endfunction

  // print one failed check and count it
  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  initial begin
    seed = 45004;
    clock = 1'b0;
    reset = 1'b1;
    cfg_run_i = 1'b0;
    {mem_wrreq_i, mem_wrlst_i, mem_rdreq_i, mem_rdlst_i, byp_rdreq_i, byp_rdlst_i} = '0;
    {mem_wrtid_i, mem_rdtid_i, byp_rdtid_i} = '0;
    {mem_wradr_i, mem_rdadr_i, byp_rdadr_i} = '0;
    ddl_rdy_i = 1'b0;
    ddl_ref_i = 1'b0;
    m_open = '0;
    in_req = 1'b0;
    ref_phase = 0;
    ref_at_dec = 1'b0;
    prev_reqs = '0;
    {cycle, errors, starts, accesses, stall_cnt} = '0;
    // first refresh level comes up between reset and the run level
    ref_cnt = 4;
    drop_cnt = -1;
  end

  always @(posedge clock) begin : main_loop
    ddr_req_t    front;
    ddr_req_t    nq;
    ddr_cmd_t    e_cmd;
    logic [2:0]  e_ba;
    logic [12:0] e_adr;
    logic [3:0]  e_tid;
    logic [12:0] row;
    cycle++;
    if (cycle == 8) reset <= 1'b0;
    if (cycle == 16) cfg_run_i <= 1'b1;

    // quiet after reset until the run level is up
    if (!reset && !cfg_run_i) begin
      assert (!mem_wrack_o && !mem_rdack_o && !byp_rdack_o && !ddl_req_o)
        else report_error("acknowledge or data layer request before run");
      assert (ddl_cmd_o == NOOP)
        else report_error($sformatf("Error: ddl_cmd_o = %h, expected %h", ddl_cmd_o, NOOP));
    end

    // acknowledges: one-hot, fixed priority on last cycle's requests
    assert ($countones({byp_rdack_o, mem_rdack_o, mem_wrack_o}) <= 1)
      else report_error("more than one acknowledge in a cycle");
    if (byp_rdack_o) begin
      assert (prev_reqs[2]) else report_error("bypass ack without request");
      exp_q.push_back(ddr_req_t'{wr: 1'b0, last: byp_rdlst_i, tid: byp_rdtid_i, adr: byp_rdadr_i});
    end
    if (mem_rdack_o) begin
      assert (prev_reqs[1] && !prev_reqs[2])
        else report_error("read ack breaks priority");
      exp_q.push_back(ddr_req_t'{wr: 1'b0, last: mem_rdlst_i, tid: mem_rdtid_i, adr: mem_rdadr_i});
    end
    if (mem_wrack_o) begin
      assert (prev_reqs[0] && prev_reqs[2:1] == 2'b00)
        else report_error("write ack breaks priority");
      exp_q.push_back(ddr_req_t'{wr: 1'b1, last: mem_wrlst_i, tid: mem_wrtid_i, adr: mem_wradr_i});
    end
    assert (exp_q.size() <= `DDR_FIFO_DEPTH + 1)
      else report_error("too many acknowledged requests in flight");
    prev_reqs = {byp_rdreq_i, mem_rdreq_i, mem_wrreq_i};

    // accepted data layer command against the model
    if (ddl_req_o && ddl_rdy_i) begin
      e_ba = '0;
      e_adr = '0;
      e_tid = '0;
      assert (ref_phase != 2) else report_error("command while refresh pending");
      if (ref_phase == 1 || (!in_req && ref_at_dec)) begin
        // refresh sequence, precharge-all only if something is open
        if (ref_phase == 0 && m_open != 0) begin
          e_cmd = PREC;
          e_adr = 13'h400;
          ref_phase = 1;
          m_open = '0;
        end else begin
          e_cmd = REFR;
          ref_phase = 2;
          drop_cnt = 1 + urand(6);
        end
      end else if (exp_q.size() == 0) begin
        report_error("command issued with no acknowledged request");
        e_cmd = ddl_cmd_o;
      end else begin
        front = exp_q[0];
        e_ba = front.adr[9:7];
        row = front.adr[22:10];
        if (m_open[e_ba] && m_row[e_ba] == row) begin
          e_cmd = front.wr ? WRIT : READ;
          e_adr = {2'b00, front.last, front.adr[6:0], 3'b000};
          e_tid = front.tid;
          if (front.last) m_open[e_ba] = 1'b0;
          void'(exp_q.pop_front());
          accesses++;
          in_req = 1'b0;
        end else if (m_open[e_ba]) begin
          e_cmd = PREC;
          m_open[e_ba] = 1'b0;
          in_req = 1'b1;
        end else begin
          e_cmd = ACTV;
          e_adr = row;
          m_open[e_ba] = 1'b1;
          m_row[e_ba] = row;
          in_req = 1'b1;
        end
      end
      assert (ddl_cmd_o == e_cmd)
        else report_error($sformatf("Error: ddl_cmd_o = %h, expected %h", ddl_cmd_o, e_cmd));
      assert (ddl_ba_o == e_ba)
        else report_error($sformatf("Error: ddl_ba_o = %h, expected %h", ddl_ba_o, e_ba));
      assert (ddl_adr_o == e_adr)
        else report_error($sformatf("Error: ddl_adr_o = %h, expected %h", ddl_adr_o, e_adr));
      assert (ddl_tid_o == e_tid)
        else report_error($sformatf("Error: ddl_tid_o = %h, expected %h", ddl_tid_o, e_tid));
    end
    // scheduler decides in idle with the level seen there
    if (!ddl_req_o) ref_at_dec = ddl_ref_i;
    if (ref_phase == 2 && !ddl_ref_i) ref_phase = 0;

    // requesters hold until acknowledged
    if (mem_wrreq_i && mem_wrack_o) begin
      mem_wrreq_i <= 1'b0;
    end else if (!mem_wrreq_i && cfg_run_i && starts < TOTAL && urand(4) == 0) begin
      nq = rand_req(1'b1);
      starts++;
      {mem_wrreq_i, mem_wrlst_i, mem_wrtid_i, mem_wradr_i} <= {1'b1, nq.last, nq.tid, nq.adr};
    end
    if (mem_rdreq_i && mem_rdack_o) begin
      mem_rdreq_i <= 1'b0;
    end else if (!mem_rdreq_i && cfg_run_i && starts < TOTAL && urand(4) == 0) begin
      nq = rand_req(1'b0);
      starts++;
      {mem_rdreq_i, mem_rdlst_i, mem_rdtid_i, mem_rdadr_i} <= {1'b1, nq.last, nq.tid, nq.adr};
    end
    if (byp_rdreq_i && byp_rdack_o) begin
      byp_rdreq_i <= 1'b0;
    end else if (!byp_rdreq_i && cfg_run_i && starts < TOTAL && urand(6) == 0) begin
      nq = rand_req(1'b0);
      starts++;
      {byp_rdreq_i, byp_rdlst_i, byp_rdtid_i, byp_rdadr_i} <= {1'b1, nq.last, nq.tid, nq.adr};
    end

    // data layer: ready mostly high, with long stalls now and then
    if (stall_cnt > 0) begin
      stall_cnt--;
      ddl_rdy_i <= 1'b0;
    end else if (urand(200) == 0) begin
      stall_cnt = 20 + urand(40);
      ddl_rdy_i <= 1'b0;
    end else begin
      ddl_rdy_i <= urand(3) != 0;
    end
    // refresh level every few hundred cycles, dropped a bit after REFRESH
    if (!reset && !ddl_ref_i) begin
      ref_cnt--;
      if (ref_cnt <= 0) ddl_ref_i <= 1'b1;
    end
    if (drop_cnt > 0) begin
      drop_cnt--;
    end else if (drop_cnt == 0) begin
      drop_cnt = -1;
      ref_cnt = 200 + urand(200);
      ddl_ref_i <= 1'b0;
    end

    if (accesses == TOTAL) begin
      assert (exp_q.size() == 0)
        else report_error("acknowledged requests left over");
    end
    if (errors != 0) begin
      $display("Checks failed");
      $fatal(1, "stopped at the first error");
    end else if (accesses == TOTAL) begin
      $display("All checks passed");
      $finish;
    end else if (cycle >= LIMIT) begin
      $display("timeout, %0d of %0d requests served", accesses, TOTAL);
      $display("Checks failed");
      $fatal(1, "cycle limit reached");
    end
  end

endmodule

// File: verilog/ddr3_cmd_scheduler.sv
`include "ddr3_defs.svh"

module ddr3_cmd_scheduler (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       cfg_run_i,
  // request queue head
  input  logic                       empty_i,
  input  ddr3_pkg::ddr_req_t         head_i,
  output logic                       pop_o,
  // data layer
  output logic                       ddl_req_o,
  input  logic                       ddl_rdy_i,
  input  logic                       ddl_ref_i,
  output ddr3_pkg::ddr_cmd_t         ddl_cmd_o,
  output logic [`DDR_TID_BITS-1:0]   ddl_tid_o,
  output logic [`DDR_BANK_BITS-1:0]  ddl_ba_o,
  output logic [`DDR_ROW_BITS-1:0]   ddl_adr_o
);

  import ddr3_pkg::*;

  localparam int NBANKS = 1 << `DDR_BANK_BITS;
  // column bits present in a request, and the dropped burst bits
  localparam int CHI = `DDR_ADDR_BITS - `DDR_ROW_BITS - `DDR_BANK_BITS;
  localparam int CLO = `DDR_COL_BITS - CHI;

  localparam logic [2:0] ST_INIT  = 3'd0;
  localparam logic [2:0] ST_IDLE  = 3'd1;
  localparam logic [2:0] ST_PREC  = 3'd2;
  localparam logic [2:0] ST_ACTV  = 3'd3;
  localparam logic [2:0] ST_ACCS  = 3'd4;
  localparam logic [2:0] ST_PREA  = 3'd5;
  localparam logic [2:0] ST_REFR  = 3'd6;
  localparam logic [2:0] ST_RWAIT = 3'd7;

  logic [2:0]                state;
  logic [2:0]                state_n;
  logic                      req_n;
  ddr_cmd_t                  cmd_n;
  logic [`DDR_BANK_BITS-1:0] ba_n;
  logic [`DDR_TID_BITS-1:0]  tid_n;
  ddr_adr_u                  adr_q;
  ddr_adr_u                  adr_n;
  logic                      fire;

  // open-row tracking
  logic [NBANKS-1:0]         bank_open;
  logic [`DDR_ROW_BITS-1:0]  open_row [NBANKS];

  // head request decode
  logic [`DDR_BANK_BITS-1:0] hd_bank;
  logic [`DDR_ROW_BITS-1:0]  hd_row;
  logic [`DDR_COL_BITS-1:0]  hd_col;
  logic                      row_hit;
  ddr_cmd_t                  acc_cmd;
  ddr_adr_u                  acc_adr;
  ddr_adr_u                  act_adr;

  assign hd_bank = head_i.adr[CHI +: `DDR_BANK_BITS];
  assign hd_row  = head_i.adr[CHI + `DDR_BANK_BITS +: `DDR_ROW_BITS];
  assign hd_col  = {head_i.adr[CHI-1:0], {CLO{1'b0}}};
  assign row_hit = bank_open[hd_bank] && (open_row[hd_bank] == hd_row);

  // command handshake this edge
  assign fire  = ddl_req_o && ddl_rdy_i;
  // queue entry retires with its read/write
  assign pop_o = fire && (state == ST_ACCS);
  assign ddl_adr_o = adr_q;

  // the two forms of the address word for the head request
  always_comb begin
    acc_adr         = '0;
    acc_adr.cas.a10 = head_i.last;
    acc_adr.cas.col = hd_col;
    act_adr         = '0;
    act_adr.row     = hd_row;
    if (head_i.wr) begin
      acc_cmd = WRIT;
    end else begin
      acc_cmd = READ;
    end
  end

  always_comb begin
    state_n = state;
    req_n   = ddl_req_o;
    cmd_n   = ddl_cmd_o;
    ba_n    = ddl_ba_o;
    tid_n   = ddl_tid_o;
    adr_n   = adr_q;
    case (state)
      ST_INIT: begin
        if (cfg_run_i) begin
          state_n = ST_IDLE;
        end
      end
      ST_IDLE: begin
        if (ddl_ref_i) begin
          // refresh wins between requests
          req_n = 1'b1;
          ba_n  = '0;
          tid_n = '0;
          adr_n = '0;
          if (|bank_open) begin
            cmd_n           = PREC;
            adr_n.cas.a10   = 1'b1;
            state_n         = ST_PREA;
          end else begin
            cmd_n   = REFR;
            state_n = ST_REFR;
          end
        end else if (!empty_i) begin
          req_n = 1'b1;
          ba_n  = hd_bank;
          if (row_hit) begin
            cmd_n   = acc_cmd;
            adr_n   = acc_adr;
            tid_n   = head_i.tid;
            state_n = ST_ACCS;
          end else if (bank_open[hd_bank]) begin
            // row conflict, close this bank only
            cmd_n   = PREC;
            adr_n   = '0;
            tid_n   = '0;
            state_n = ST_PREC;
          end else begin
            cmd_n   = ACTV;
            adr_n   = act_adr;
            tid_n   = '0;
            state_n = ST_ACTV;
          end
        end
      end
      ST_PREC: begin
        if (fire) begin
          cmd_n   = ACTV;
          adr_n   = act_adr;
          state_n = ST_ACTV;
        end
      end
      ST_ACTV: begin
        if (fire) begin
          cmd_n   = acc_cmd;
          adr_n   = acc_adr;
          tid_n   = head_i.tid;
          state_n = ST_ACCS;
        end
      end
      ST_ACCS: begin
        if (fire) begin
          req_n   = 1'b0;
          cmd_n   = NOOP;
          tid_n   = '0;
          state_n = ST_IDLE;
        end
      end
      ST_PREA: begin
        if (fire) begin
          cmd_n   = REFR;
          adr_n   = '0;
          state_n = ST_REFR;
        end
      end
      ST_REFR: begin
        if (fire) begin
          req_n   = 1'b0;
          cmd_n   = NOOP;
          state_n = ST_RWAIT;
        end
      end
      default: begin
        // hold off new requests until the data layer drops its level
        if (!ddl_ref_i) begin
          state_n = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ST_INIT;
      ddl_req_o <= 1'b0;
      ddl_cmd_o <= NOOP;
    end else begin
      state     <= state_n;
      ddl_req_o <= req_n;
      ddl_cmd_o <= cmd_n;
    end
  end

  // command payload
  always_ff @(posedge clock) begin
    ddl_ba_o  <= ba_n;
    ddl_tid_o <= tid_n;
    adr_q     <= adr_n;
  end

  // bank state follows accepted commands
  always_ff @(posedge clock) begin
    if (reset) begin
      bank_open <= '0;
    end else if (fire) begin
      case (state)
        ST_PREC: bank_open[ddl_ba_o] <= 1'b0;
        ST_ACTV: bank_open[ddl_ba_o] <= 1'b1;
        // auto-precharge closes the bank on the same edge
        ST_ACCS: begin
          if (adr_q.cas.a10) begin
            bank_open[ddl_ba_o] <= 1'b0;
          end
        end
        ST_PREA: bank_open <= '0;
        default: bank_open <= bank_open;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (fire && state == ST_ACTV) begin
      open_row[ddl_ba_o] <= adr_q.row;
    end
  end

endmodule

// File: verilog/ddr3_ctrl_top.sv
`include "ddr3_defs.svh"

module ddr3_ctrl_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       cfg_run_i,
  // write port
  input  logic                       mem_wrreq_i,
  input  logic                       mem_wrlst_i,
  input  logic [`DDR_TID_BITS-1:0]   mem_wrtid_i,
  input  logic [`DDR_ADDR_BITS-1:0]  mem_wradr_i,
  output logic                       mem_wrack_o,
  // read port
  input  logic                       mem_rdreq_i,
  input  logic                       mem_rdlst_i,
  input  logic [`DDR_TID_BITS-1:0]   mem_rdtid_i,
  input  logic [`DDR_ADDR_BITS-1:0]  mem_rdadr_i,
  output logic                       mem_rdack_o,
  // fast-path read port
  input  logic                       byp_rdreq_i,
  input  logic                       byp_rdlst_i,
  input  logic [`DDR_TID_BITS-1:0]   byp_rdtid_i,
  input  logic [`DDR_ADDR_BITS-1:0]  byp_rdadr_i,
  output logic                       byp_rdack_o,
  // data layer
  output logic                       ddl_req_o,
  input  logic                       ddl_rdy_i,
  input  logic                       ddl_ref_i,
  output ddr3_pkg::ddr_cmd_t         ddl_cmd_o,
  output logic [`DDR_TID_BITS-1:0]   ddl_tid_o,
  output logic [`DDR_BANK_BITS-1:0]  ddl_ba_o,
  output logic [`DDR_ROW_BITS-1:0]   ddl_adr_o
);

  import ddr3_pkg::*;

  // arbiter to queue
  logic     fifo_full;
  logic     push;
  ddr_req_t push_data;
  // queue to scheduler
  logic     fifo_empty;
  logic     pop;
  ddr_req_t head;

  ddr3_req_arbiter ddr3_req_arbiter_inst (
    .clock       (clock),
    .reset       (reset),
    .fifo_full_i (fifo_full),
    .mem_wrreq_i (mem_wrreq_i),
    .mem_wrlst_i (mem_wrlst_i),
    .mem_wrtid_i (mem_wrtid_i),
    .mem_wradr_i (mem_wradr_i),
    .mem_wrack_o (mem_wrack_o),
    .mem_rdreq_i (mem_rdreq_i),
    .mem_rdlst_i (mem_rdlst_i),
    .mem_rdtid_i (mem_rdtid_i),
    .mem_rdadr_i (mem_rdadr_i),
    .mem_rdack_o (mem_rdack_o),
    .byp_rdreq_i (byp_rdreq_i),
    .byp_rdlst_i (byp_rdlst_i),
    .byp_rdtid_i (byp_rdtid_i),
    .byp_rdadr_i (byp_rdadr_i),
    .byp_rdack_o (byp_rdack_o),
    .push_o      (push),
    .push_data_o (push_data)
  );

  ddr3_req_fifo ddr3_req_fifo_inst (
    .clock       (clock),
    .reset       (reset),
    .push_i      (push),
    .push_data_i (push_data),
    .full_o      (fifo_full),
    .pop_i       (pop),
    .empty_o     (fifo_empty),
    .head_o      (head)
  );

  ddr3_cmd_scheduler ddr3_cmd_scheduler_inst (
    .clock     (clock),
    .reset     (reset),
    .cfg_run_i (cfg_run_i),
    .empty_i   (fifo_empty),
    .head_i    (head),
    .pop_o     (pop),
    .ddl_req_o (ddl_req_o),
    .ddl_rdy_i (ddl_rdy_i),
    .ddl_ref_i (ddl_ref_i),
    .ddl_cmd_o (ddl_cmd_o),
    .ddl_tid_o (ddl_tid_o),
    .ddl_ba_o  (ddl_ba_o),
    .ddl_adr_o (ddl_adr_o)
  );

endmodule

// File: verilog/ddr3_defs.svh
`ifndef DDR3_DEFS_SVH
`define DDR3_DEFS_SVH

// sizes for a 1Gb x16 ddr3 part

// row address, also the width of the ddl address bus
`define DDR_ROW_BITS 13

// eight banks
`define DDR_BANK_BITS 3

// full column address as seen by the device
`define DDR_COL_BITS 10

// request address is {row, bank, col[9:3]}
// bursts are aligned, so the low 3 column bits never arrive
`define DDR_ADDR_BITS 23

// transaction id carried from the request port to the data layer
`define DDR_TID_BITS 4

// request queue entries
// keep this a power of two, the pointers wrap by overflow
`define DDR_FIFO_DEPTH 4

`endif

// File: verilog/ddr3_pkg.sv
`include "ddr3_defs.svh"

package ddr3_pkg;

  // ddr3 command codes as {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    PREC = 3'b010,
    ACTV = 3'b011,
    READ = 3'b101,
    WRIT = 3'b100,
    REFR = 3'b001
  } ddr_cmd_t;

  // one queued request, 29 bits
  typedef struct packed {
    // set only for the write port
    logic                       wr;
    // last access to this row, close it afterwards
    logic                       last;
    logic [`DDR_TID_BITS-1:0]   tid;
    // {row, bank, upper column}
    logic [`DDR_ADDR_BITS-1:0]  adr;
  } ddr_req_t;

  // column view of the ddl address word
  typedef struct packed {
    logic [`DDR_ROW_BITS-`DDR_COL_BITS-2:0] spare;
    // auto-precharge on read/write, all banks on precharge
    logic                                   a10;
    logic [`DDR_COL_BITS-1:0]               col;
  } ddr_cas_t;

  // the ddl address word, row for activate, column view otherwise
  typedef union packed {
    logic [`DDR_ROW_BITS-1:0] row;
    ddr_cas_t                 cas;
  } ddr_adr_u;

endpackage

// File: verilog/ddr3_req_arbiter.sv
`include "ddr3_defs.svh"

module ddr3_req_arbiter (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       fifo_full_i,
  // write port
  input  logic                       mem_wrreq_i,
  input  logic                       mem_wrlst_i,
  input  logic [`DDR_TID_BITS-1:0]   mem_wrtid_i,
  input  logic [`DDR_ADDR_BITS-1:0]  mem_wradr_i,
  output logic                       mem_wrack_o,
  // read port
  input  logic                       mem_rdreq_i,
  input  logic                       mem_rdlst_i,
  input  logic [`DDR_TID_BITS-1:0]   mem_rdtid_i,
  input  logic [`DDR_ADDR_BITS-1:0]  mem_rdadr_i,
  output logic                       mem_rdack_o,
  // fast-path read port
  input  logic                       byp_rdreq_i,
  input  logic                       byp_rdlst_i,
  input  logic [`DDR_TID_BITS-1:0]   byp_rdtid_i,
  input  logic [`DDR_ADDR_BITS-1:0]  byp_rdadr_i,
  output logic                       byp_rdack_o,
  // queue write side
  output logic                       push_o,
  output ddr3_pkg::ddr_req_t         push_data_o
);

  logic acked;
  logic take;

  // an ack last cycle means that requester still holds its level
  assign acked = mem_wrack_o | mem_rdack_o | byp_rdack_o;

  // accept one request per two cycles at most, never into a full queue
  assign take = !fifo_full_i && !acked && (byp_rdreq_i || mem_rdreq_i || mem_wrreq_i);

  // one-hot acks, bypass beats read beats write
  always_ff @(posedge clock) begin
    if (reset) begin
      byp_rdack_o <= 1'b0;
      mem_rdack_o <= 1'b0;
      mem_wrack_o <= 1'b0;
      push_o      <= 1'b0;
    end else begin
      byp_rdack_o <= take && byp_rdreq_i;
      mem_rdack_o <= take && !byp_rdreq_i && mem_rdreq_i;
      mem_wrack_o <= take && !byp_rdreq_i && !mem_rdreq_i && mem_wrreq_i;
      push_o      <= take;
    end
  end

  // winner's fields, pushed along with the ack
  always_ff @(posedge clock) begin
    if (take) begin
      if (byp_rdreq_i) begin
        push_data_o <= '{wr: 1'b0, last: byp_rdlst_i, tid: byp_rdtid_i, adr: byp_rdadr_i};
      end else if (mem_rdreq_i) begin
        push_data_o <= '{wr: 1'b0, last: mem_rdlst_i, tid: mem_rdtid_i, adr: mem_rdadr_i};
      end else begin
        push_data_o <= '{wr: 1'b1, last: mem_wrlst_i, tid: mem_wrtid_i, adr: mem_wradr_i};
      end
    end
  end

endmodule

// File: verilog/ddr3_req_fifo.sv
`include "ddr3_defs.svh"

module ddr3_req_fifo (
  input  logic               clock,
  input  logic               reset,
  // write side, from the arbiter
  input  logic               push_i,
  input  ddr3_pkg::ddr_req_t push_data_i,
  output logic               full_o,
  // read side, to the scheduler
  input  logic               pop_i,
  output logic               empty_o,
  output ddr3_pkg::ddr_req_t head_o
);

  import ddr3_pkg::*;

  localparam int ABITS = $clog2(`DDR_FIFO_DEPTH);
  localparam int CBITS = ABITS + 1;
  localparam logic [CBITS-1:0] DEPTH = CBITS'(`DDR_FIFO_DEPTH);

  ddr_req_t         mem [`DDR_FIFO_DEPTH];
  logic [ABITS-1:0] wr_ptr;
  logic [ABITS-1:0] rd_ptr;
  logic [CBITS-1:0] count;
  logic [CBITS-1:0] count_n;

  // occupancy after this edge, push and pop may coincide
  assign count_n = count + CBITS'(push_i) - CBITS'(pop_i);

  // first-word fall-through
  assign head_o = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      full_o  <= 1'b0;
      empty_o <= 1'b1;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count   <= count_n;
      // flags registered from the next count
      full_o  <= count_n == DEPTH;
      empty_o <= count_n == '0;
    end
  end

  // storage
  always_ff @(posedge clock) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

endmodule
